/* rtl/if_addr_pkg.sv */
// address-side definitions for the fetch stage
// debug entry addresses are fixed here and must match the debug module map
// boot_addr and mtvec are assumed aligned to 256 bytes

`default_nettype none

package if_addr_pkg;

  //////////////////////////////
  // selector encodings
  //////////////////////////////

  // source of the next fetch address
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // flavour of exception handler address
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  //////////////////////////////
  // fixed addresses
  //////////////////////////////

  // debug module halt and exception entry points
  localparam logic [31:0] DmHaltAddr      = 32'h1A11_0800;
  localparam logic [31:0] DmExceptionAddr = 32'h1A11_0808;

  // low byte placed under boot_addr[31:8]
  localparam logic [7:0] BootOffset = 8'h80;

  // mtvec low bits ignored, also the boot alignment
  localparam int unsigned MtvecAlignBits = 8;

  // interrupt number width for vectored mode
  localparam int unsigned IrqIdW = 5;

endpackage

`default_nettype wire

/* rtl/if_bus_pkg.sv */
// fetch-side definitions shared by the datapath modules
// instructions are always one aligned 32-bit word

`default_nettype none

package if_bus_pkg;

  // address and instruction word width
  localparam int unsigned XLEN = 32;

  // sequential pc step, one word
  localparam logic [XLEN-1:0] InstrBytes = 32'd4;

  // byte offset bits inside a word, forced to zero on the bus
  localparam int unsigned WordAlignBits = 2;

  // prefetch queue sizing
  localparam int unsigned FifoDepth = 2;
  localparam int unsigned FifoPtrW  = $clog2(FifoDepth);
  localparam int unsigned FifoCntW  = FifoPtrW + 1;

  // fill level at which no further request may issue
  localparam logic [FifoCntW-1:0] FifoFull = FifoCntW'(FifoDepth);

endpackage

`default_nettype wire

/* rtl/pc_target_sel.sv */
// next fetch address selection, purely combinational
// the low byte of boot_addr_i and mtvec is ignored

`timescale 1ns/10ps
`default_nettype none

module pc_target_sel (
  input  logic                                pc_set_i,
  input  if_addr_pkg::pc_sel_e                pc_sel_i,
  input  if_addr_pkg::exc_pc_sel_e            exc_pc_sel_i,
  input  logic [if_addr_pkg::IrqIdW-1:0]      irq_id_i,
  input  logic [if_bus_pkg::XLEN-1:0]         boot_addr_i,
  input  logic [if_bus_pkg::XLEN-1:0]         branch_target_i,
  input  logic [if_bus_pkg::XLEN-1:0]         csr_mtvec_i,
  input  logic [if_bus_pkg::XLEN-1:0]         csr_mepc_i,
  input  logic [if_bus_pkg::XLEN-1:0]         csr_depc_i,
  output logic [if_bus_pkg::XLEN-1:0]         fetch_addr_o,
  output logic                                csr_mtvec_init_o
);

  logic [if_bus_pkg::XLEN-1:0] mtvec_base;
  logic [if_bus_pkg::XLEN-1:0] irq_offset;
  logic [if_bus_pkg::XLEN-1:0] exc_pc;
  logic [if_bus_pkg::XLEN-1:0] target;

  // handler table base, low byte dropped
  assign mtvec_base = {csr_mtvec_i[if_bus_pkg::XLEN-1:if_addr_pkg::MtvecAlignBits],
                       {if_addr_pkg::MtvecAlignBits{1'b0}}};

  // one word per interrupt line
  assign irq_offset = {{(if_bus_pkg::XLEN - if_addr_pkg::IrqIdW - 2){1'b0}}, irq_id_i, 2'b00};

  // exception handler address
  always_comb begin
    unique case (exc_pc_sel_i)
      if_addr_pkg::EXC_PC_EXC:     exc_pc = mtvec_base;
      if_addr_pkg::EXC_PC_IRQ:     exc_pc = mtvec_base + irq_offset;
      if_addr_pkg::EXC_PC_DBD:     exc_pc = if_addr_pkg::DmHaltAddr;
      if_addr_pkg::EXC_PC_DBG_EXC: exc_pc = if_addr_pkg::DmExceptionAddr;
      default:                     exc_pc = mtvec_base;
    endcase
  end

  // fetch address mux, boot is the fallback for unused codes
  always_comb begin
    unique case (pc_sel_i)
      if_addr_pkg::PC_JUMP: target = branch_target_i;
      if_addr_pkg::PC_EXC:  target = exc_pc;
      if_addr_pkg::PC_ERET: target = csr_mepc_i;
      if_addr_pkg::PC_DRET: target = csr_depc_i;
      default: begin
        target = {boot_addr_i[if_bus_pkg::XLEN-1:if_addr_pkg::MtvecAlignBits],
                  if_addr_pkg::BootOffset};
      end
    endcase
  end

  // word aligned fetch only
  assign fetch_addr_o = {target[if_bus_pkg::XLEN-1:if_bus_pkg::WordAlignBits],
                         {if_bus_pkg::WordAlignBits{1'b0}}};

  // csr file loads mtvec from boot_addr on the boot jump
  assign csr_mtvec_init_o = pc_set_i & (pc_sel_i == if_addr_pkg::PC_BOOT);

endmodule

`default_nettype wire

/* rtl/prefetch_buffer.sv */
// word prefetcher on a req/gnt/rvalid bus, one request in flight at most
// a branch flushes the queue and drops a response still due
// a new request waits while a response is pending, even on a branch

`timescale 1ns/10ps
`default_nettype none

module prefetch_buffer (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        req_i,
  input  logic                        branch_i,
  input  logic [if_bus_pkg::XLEN-1:0] branch_addr_i,
  input  logic                        fetch_ready_i,
  output logic                        fetch_valid_o,
  output logic [if_bus_pkg::XLEN-1:0] fetch_rdata_o,
  output logic [if_bus_pkg::XLEN-1:0] fetch_addr_o,
  output logic                        fetch_err_o,
  output logic                        instr_req_o,
  output logic [if_bus_pkg::XLEN-1:0] instr_addr_o,
  input  logic                        instr_gnt_i,
  input  logic                        instr_rvalid_i,
  input  logic [if_bus_pkg::XLEN-1:0] instr_rdata_i,
  input  logic                        instr_err_i,
  output logic                        busy_o
);

  // next word to request and address of the queue head
  logic [if_bus_pkg::XLEN-1:0]     req_addr_q;
  logic [if_bus_pkg::XLEN-1:0]     out_addr_q;
  logic                            outstanding_q;
  logic                            discard_q;

  // queue storage, data and error per entry
  logic [if_bus_pkg::XLEN-1:0]     data_q [if_bus_pkg::FifoDepth];
  logic [if_bus_pkg::FifoDepth-1:0] err_q;
  logic [if_bus_pkg::FifoPtrW-1:0] wptr_q;
  logic [if_bus_pkg::FifoPtrW-1:0] rptr_q;
  logic [if_bus_pkg::FifoCntW-1:0] count_q;
  logic [if_bus_pkg::FifoCntW-1:0] fill;

  logic room;
  logic grant;
  logic push;
  logic pop;

  //////////////////////////////
  // bus side
  //////////////////////////////

  // an in-flight word reserves its queue slot
  assign fill = count_q + {{if_bus_pkg::FifoPtrW{1'b0}}, outstanding_q};
  assign room = (fill != if_bus_pkg::FifoFull);

  // bus slot is free once the pending response shows up
  assign instr_req_o  = req_i & (branch_i | room) & (~outstanding_q | instr_rvalid_i);
  assign instr_addr_o = branch_i ? branch_addr_i : req_addr_q;
  assign grant        = instr_req_o & instr_gnt_i;

  // responses cancelled by a branch never enter the queue
  assign push = instr_rvalid_i & ~discard_q & ~branch_i;
  assign pop  = fetch_valid_o & fetch_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= 1'b0;
      discard_q     <= 1'b0;
      req_addr_q    <= '0;
    end else begin
      outstanding_q <= grant | (outstanding_q & ~instr_rvalid_i);
      // a branch marks a still pending response as stale
      if (branch_i) begin
        discard_q <= outstanding_q & ~instr_rvalid_i;
      end else begin
        discard_q <= discard_q & ~instr_rvalid_i;
      end
      // request pointer steps past each granted word
      if (grant) begin
        req_addr_q <= instr_addr_o + if_bus_pkg::InstrBytes;
      end else if (branch_i) begin
        req_addr_q <= branch_addr_i;
      end
    end
  end

  //////////////////////////////
  // queue side
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q     <= '0;
      rptr_q     <= '0;
      count_q    <= '0;
      out_addr_q <= '0;
    end else if (branch_i) begin
      wptr_q     <= '0;
      rptr_q     <= '0;
      count_q    <= '0;
      out_addr_q <= branch_addr_i;
    end else begin
      if (push) begin
        wptr_q <= wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q     <= rptr_q + 1'b1;
        out_addr_q <= out_addr_q + if_bus_pkg::InstrBytes;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // payload written in place, only count and pointers decide validity
  always_ff @(posedge clk_i) begin
    if (push) begin
      data_q[wptr_q] <= instr_rdata_i;
      err_q[wptr_q]  <= instr_err_i;
    end
  end

  assign fetch_valid_o = (count_q != '0);
  assign fetch_rdata_o = data_q[rptr_q];
  assign fetch_err_o   = err_q[rptr_q];
  // head address stays meaningful with an empty queue
  assign fetch_addr_o  = out_addr_q;

  assign busy_o = outstanding_q | instr_req_o;

endmodule

`default_nettype wire

/* rtl/if_id_reg.sv */
// IF-ID pipeline registers with valid and new flags
// payload registers load only on consume and have no reset

`timescale 1ns/10ps
`default_nettype none

module if_id_reg (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        fetch_valid_i,
  input  logic [if_bus_pkg::XLEN-1:0] fetch_rdata_i,
  input  logic [if_bus_pkg::XLEN-1:0] fetch_addr_i,
  input  logic                        fetch_err_i,
  input  logic                        pmp_err_if_i,
  input  logic                        id_in_ready_i,
  input  logic                        pc_set_i,
  input  logic                        instr_valid_clear_i,
  output logic                        fetch_ready_o,
  output logic                        instr_valid_id_o,
  output logic                        instr_new_id_o,
  output logic [if_bus_pkg::XLEN-1:0] instr_rdata_id_o,
  output logic [if_bus_pkg::XLEN-1:0] pc_id_o,
  output logic                        instr_fetch_err_o,
  output logic                        seq_ok_o
);

  logic consume;
  logic if_err;

  // a redirect squashes the word on offer this cycle
  assign consume       = fetch_valid_i & id_in_ready_i & ~pc_set_i;
  assign fetch_ready_o = consume;

  // bus error or pmp fault on this word
  assign if_err = fetch_err_i | pmp_err_if_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_id_o <= 1'b0;
      instr_new_id_o   <= 1'b0;
    end else begin
      // valid holds until cleared by ID or dropped by a redirect
      instr_valid_id_o <= consume |
                          (instr_valid_id_o & ~instr_valid_clear_i & ~pc_set_i);
      // new is a single cycle pulse per consumed word
      instr_new_id_o   <= consume;
    end
  end

  always_ff @(posedge clk_i) begin
    if (consume) begin
      instr_rdata_id_o  <= fetch_rdata_i;
      pc_id_o           <= fetch_addr_i;
      instr_fetch_err_o <= if_err;
    end
  end

  // clean word, usable as a base for the increment check
  assign seq_ok_o = ~instr_fetch_err_o;

endmodule

`default_nettype wire

/* rtl/pc_incr_check.sv */
// flags a fetch address that is not the ID pc plus four
// the check is idle after reset, any redirect and any faulted word

`timescale 1ns/10ps
`default_nettype none

module pc_incr_check (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        instr_new_id_i,
  input  logic                        seq_ok_i,
  input  logic                        pc_set_i,
  input  logic [if_bus_pkg::XLEN-1:0] pc_id_i,
  input  logic [if_bus_pkg::XLEN-1:0] fetch_addr_i,
  output logic                        pc_mismatch_alert_o
);

  logic                        seq_q;
  logic [if_bus_pkg::XLEN-1:0] pc_next;

  // armed by a clean word in ID, disarmed by a redirect
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seq_q <= 1'b0;
    end else if (pc_set_i) begin
      seq_q <= 1'b0;
    end else if (instr_new_id_i) begin
      seq_q <= seq_ok_i;
    end
  end

  assign pc_next = pc_id_i + if_bus_pkg::InstrBytes;

  // both operands are registers, so the alert has no input path
  assign pc_mismatch_alert_o = seq_q & (fetch_addr_i != pc_next);

endmodule

`default_nettype wire

/* rtl/ifs_fetch_stage.sv */
// instruction fetch stage top
// hold req_i high to fetch, pc_set_i with pc_sel_i starts a new stream
// instructions are single aligned words, no compressed support

`timescale 1ns/10ps
`default_nettype none

module ifs_fetch_stage (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           req_i,
  input  logic [if_bus_pkg::XLEN-1:0]    boot_addr_i,
  // redirect control
  input  logic                           pc_set_i,
  input  if_addr_pkg::pc_sel_e           pc_sel_i,
  input  if_addr_pkg::exc_pc_sel_e       exc_pc_sel_i,
  input  logic [if_addr_pkg::IrqIdW-1:0] irq_id_i,
  input  logic [if_bus_pkg::XLEN-1:0]    branch_target_i,
  input  logic [if_bus_pkg::XLEN-1:0]    csr_mtvec_i,
  input  logic [if_bus_pkg::XLEN-1:0]    csr_mepc_i,
  input  logic [if_bus_pkg::XLEN-1:0]    csr_depc_i,
  output logic                           csr_mtvec_init_o,
  // instruction bus
  output logic                           instr_req_o,
  output logic [if_bus_pkg::XLEN-1:0]    instr_addr_o,
  input  logic                           instr_gnt_i,
  input  logic                           instr_rvalid_i,
  input  logic [if_bus_pkg::XLEN-1:0]    instr_rdata_i,
  input  logic                           instr_err_i,
  // ID stage side
  input  logic                           pmp_err_if_i,
  input  logic                           id_in_ready_i,
  input  logic                           instr_valid_clear_i,
  output logic                           instr_valid_id_o,
  output logic                           instr_new_id_o,
  output logic [if_bus_pkg::XLEN-1:0]    instr_rdata_id_o,
  output logic [if_bus_pkg::XLEN-1:0]    pc_id_o,
  output logic                           instr_fetch_err_o,
  output logic [if_bus_pkg::XLEN-1:0]    pc_if_o,
  output logic                           pc_mismatch_alert_o,
  output logic                           if_busy_o
);

  logic [if_bus_pkg::XLEN-1:0] fetch_addr_n;
  logic                        fetch_valid;
  logic                        fetch_ready;
  logic [if_bus_pkg::XLEN-1:0] fetch_rdata;
  logic                        fetch_err;
  logic                        seq_ok;

  pc_target_sel i_pc_target_sel (
    .pc_set_i         (pc_set_i),
    .pc_sel_i         (pc_sel_i),
    .exc_pc_sel_i     (exc_pc_sel_i),
    .irq_id_i         (irq_id_i),
    .boot_addr_i      (boot_addr_i),
    .branch_target_i  (branch_target_i),
    .csr_mtvec_i      (csr_mtvec_i),
    .csr_mepc_i       (csr_mepc_i),
    .csr_depc_i       (csr_depc_i),
    .fetch_addr_o     (fetch_addr_n),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  // every pc_set_i is a branch for the prefetcher
  prefetch_buffer i_prefetch_buffer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .branch_i       (pc_set_i),
    .branch_addr_i  (fetch_addr_n),
    .fetch_ready_i  (fetch_ready),
    .fetch_valid_o  (fetch_valid),
    .fetch_rdata_o  (fetch_rdata),
    .fetch_addr_o   (pc_if_o),
    .fetch_err_o    (fetch_err),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i),
    .busy_o         (if_busy_o)
  );

  if_id_reg i_if_id_reg (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_valid_i       (fetch_valid),
    .fetch_rdata_i       (fetch_rdata),
    .fetch_addr_i        (pc_if_o),
    .fetch_err_i         (fetch_err),
    .pmp_err_if_i        (pmp_err_if_i),
    .id_in_ready_i       (id_in_ready_i),
    .pc_set_i            (pc_set_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .fetch_ready_o       (fetch_ready),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .pc_id_o             (pc_id_o),
    .instr_fetch_err_o   (instr_fetch_err_o),
    .seq_ok_o            (seq_ok)
  );

  pc_incr_check i_pc_incr_check (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .instr_new_id_i      (instr_new_id_o),
    .seq_ok_i            (seq_ok),
    .pc_set_i            (pc_set_i),
    .pc_id_i             (pc_id_o),
    .fetch_addr_i        (pc_if_o),
    .pc_mismatch_alert_o (pc_mismatch_alert_o)
  );

endmodule

`default_nettype wire

/* sim/fetch_stage_assert.sv */
// bus and selector checks, bound into the fetch stage top
// all properties are idle while rst_ni is low

`timescale 1ns/10ps
`default_nettype none

module fetch_stage_assert (
  input logic        clk_i,
  input logic        rst_ni,
  input logic        pc_set_i,
  input logic [2:0]  pc_sel_i,
  input logic [1:0]  exc_pc_sel_i,
  input logic [4:0]  irq_id_i,
  input logic        instr_req_o,
  input logic [31:0] instr_addr_o,
  input logic        instr_gnt_i,
  input logic        instr_rvalid_i
);

  // one response is owed per grant
  logic outstanding_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= 1'b0;
    end else if (instr_req_o && instr_gnt_i) begin
      outstanding_q <= 1'b1;
    end else if (instr_rvalid_i) begin
      outstanding_q <= 1'b0;
    end
  end

  // a redirect may replace the address of a waiting request
  addr_stable_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o && !instr_gnt_i |=> pc_set_i || (instr_req_o && $stable(instr_addr_o)))
    else $error("instruction address changed before its grant");

  addr_aligned_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o |-> instr_addr_o[1:0] == 2'b00)
    else $error("instruction address not word aligned");

  // the pending response may arrive in the same cycle as the next grant
  single_outstanding_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o && instr_gnt_i |-> !outstanding_q || instr_rvalid_i)
    else $error("grant while a response is still outstanding");

  sel_known_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pc_set_i |-> !$isunknown({pc_sel_i, exc_pc_sel_i, irq_id_i}))
    else $error("pc selectors unknown during pc_set_i");

endmodule

bind ifs_fetch_stage fetch_stage_assert i_fetch_stage_assert (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .pc_set_i       (pc_set_i),
  .pc_sel_i       (pc_sel_i),
  .exc_pc_sel_i   (exc_pc_sel_i),
  .irq_id_i       (irq_id_i),
  .instr_req_o    (instr_req_o),
  .instr_addr_o   (instr_addr_o),
  .instr_gnt_i    (instr_gnt_i),
  .instr_rvalid_i (instr_rvalid_i)
);

`default_nettype wire

/* sim/tb_fetch_stage.sv */
// directed testbench for the fetch stage
// bus model grants after 0 to 2 cycles and answers 1 to 2 cycles after the grant
// inputs change 2 ns after the rising edge and ID outputs are logged at the falling edge

`timescale 1ns/10ps
`default_nettype none

module tb_fetch_stage;

  localparam int unsigned ClkPeriod = 40;
  localparam logic [31:0] DataMask  = 32'hC0DE_0000;
  localparam logic [31:0] ErrAddr   = 32'h0000_7008;
  localparam logic [31:0] NoErr     = 32'hFFFF_FFFC;
  // cycle budgets of the six tests
  localparam int unsigned BudgetSum = 80 + 120 + 160 + 200 + 120 + 40;

  logic                           clk_i;
  logic                           rst_ni;
  logic                           req_i;
  logic [31:0]                    boot_addr_i;
  logic                           pc_set_i;
  if_addr_pkg::pc_sel_e           pc_sel_i;
  if_addr_pkg::exc_pc_sel_e       exc_pc_sel_i;
  logic [if_addr_pkg::IrqIdW-1:0] irq_id_i;
  logic [31:0]                    branch_target_i;
  logic [31:0]                    csr_mtvec_i;
  logic [31:0]                    csr_mepc_i;
  logic [31:0]                    csr_depc_i;
  logic                           csr_mtvec_init_o;
  logic                           instr_req_o;
  logic [31:0]                    instr_addr_o;
  logic                           instr_gnt_i;
  logic                           instr_rvalid_i;
  logic [31:0]                    instr_rdata_i;
  logic                           instr_err_i;
  logic                           pmp_err_if_i;
  logic                           id_in_ready_i;
  logic                           instr_valid_clear_i;
  logic                           instr_valid_id_o;
  logic                           instr_new_id_o;
  logic [31:0]                    instr_rdata_id_o;
  logic [31:0]                    pc_id_o;
  logic                           instr_fetch_err_o;
  logic [31:0]                    pc_if_o;
  logic                           pc_mismatch_alert_o;
  logic                           if_busy_o;

  // what ID received since the last redirect
  logic [31:0] pc_log[$];
  logic [31:0] data_log[$];
  logic        err_log[$];
  logic        alert_seen;
  logic [31:0] rng_bus;
  logic [31:0] rng_rdy;
  int unsigned errors;
  int unsigned errors_at_start;
  int unsigned tests_run;
  int unsigned tests_failed;

  ifs_fetch_stage i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  //////////////////////////////
  // bus memory model
  //////////////////////////////

  initial begin : mem_model
    int unsigned gnt_wait;
    int unsigned resp_cnt;
    logic [31:0] resp_addr;
    logic        req_s;
    logic        gnt_s;
    logic [31:0] addr_s;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    instr_err_i    = 1'b0;
    rng_bus        = 32'd10;
    gnt_wait       = 0;
    resp_cnt       = 0;
    resp_addr      = '0;
    wait (rst_ni === 1'b1);
    forever begin
      @(negedge clk_i);
      req_s  = instr_req_o;
      gnt_s  = instr_gnt_i;
      addr_s = instr_addr_o;
      @(posedge clk_i);
      #2;
      instr_rvalid_i = 1'b0;
      instr_err_i    = 1'b0;
      if (req_s && gnt_s) begin
        // on a grant pick the response delay and the wait before the next grant
        resp_addr = addr_s;
        rng_bus   = xorshift(rng_bus);
        resp_cnt  = 1 + rng_bus % 2;
        rng_bus   = xorshift(rng_bus);
        gnt_wait  = rng_bus % 3;
      end else if (req_s && gnt_wait != 0) begin
        gnt_wait--;
      end
      instr_gnt_i = (gnt_wait == 0);
      if (resp_cnt != 0) begin
        resp_cnt--;
        if (resp_cnt == 0) begin
          instr_rvalid_i = 1'b1;
          instr_rdata_i  = resp_addr ^ DataMask;
          instr_err_i    = (resp_addr == ErrAddr);
        end
      end
    end
  end

  initial begin : id_monitor
    forever begin
      @(negedge clk_i);
      if (rst_ni && instr_new_id_o) begin
        pc_log.push_back(pc_id_o);
        data_log.push_back(instr_rdata_id_o);
        err_log.push_back(instr_fetch_err_o);
      end
      if (rst_ni && pc_mismatch_alert_o) begin
        alert_seen = 1'b1;
      end
    end
  end

  initial begin : watchdog
    #(BudgetSum * 2 * ClkPeriod);
    $display("ERROR watchdog expired after %0d cycles, run did not complete", BudgetSum * 2);
    $display("TEST FAILED");
    $finish;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("FAIL t=%0t %s got %h exp %h", $time, name, got, exp);
    errors++;
  endtask

  task automatic report_problem(input string what);
    $display("ERROR t=%0t %s", $time, what);
    errors++;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == errors_at_start) begin
      $display("test %s passed", name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", name, errors - errors_at_start);
    end
    errors_at_start = errors;
  endtask

  // one cycle of pc_set_i and a fresh log for the new stream
  task automatic redirect(input if_addr_pkg::pc_sel_e sel, input if_addr_pkg::exc_pc_sel_e exc);
    pc_set_i     = 1'b1;
    pc_sel_i     = sel;
    exc_pc_sel_i = exc;
    #3;
    if (csr_mtvec_init_o !== (sel == if_addr_pkg::PC_BOOT)) begin
      report_mismatch("csr_mtvec_init_o", 32'(csr_mtvec_init_o),
                      32'(sel == if_addr_pkg::PC_BOOT));
    end
    next_cycle();
    pc_set_i = 1'b0;
    pc_log.delete();
    data_log.delete();
    err_log.delete();
  endtask

  // n words from start where only err_pc may carry an error
  task automatic expect_stream(input logic [31:0] start, input int unsigned n,
                               input logic [31:0] err_pc, input bit rand_ready);
    int unsigned waited;
    int unsigned k;
    logic [31:0] pc_exp;
    waited = 0;
    while (pc_log.size() < n && waited < n * 12 + 20) begin
      if (rand_ready) begin
        rng_rdy       = xorshift(rng_rdy);
        id_in_ready_i = rng_rdy[4];
      end
      next_cycle();
      waited++;
    end
    id_in_ready_i = 1'b1;
    if (pc_log.size() < n) begin
      report_problem($sformatf("only %0d of %0d instructions reached ID", pc_log.size(), n));
    end
    // queue head sits one word past everything consumed so far
    pc_exp = start + 32'((pc_log.size() + instr_new_id_o) * 4);
    if (pc_if_o !== pc_exp) begin
      report_mismatch("pc_if_o", pc_if_o, pc_exp);
    end
    for (k = 0; k < n && k < pc_log.size(); k++) begin
      pc_exp = start + 32'(k * 4);
      if (pc_log[k] !== pc_exp) begin
        report_mismatch("pc_id_o", pc_log[k], pc_exp);
      end
      if (data_log[k] !== (pc_exp ^ DataMask)) begin
        report_mismatch("instr_rdata_id_o", data_log[k], pc_exp ^ DataMask);
      end
      if (err_log[k] !== (pc_exp == err_pc)) begin
        report_mismatch("instr_fetch_err_o", 32'(err_log[k]), 32'(pc_exp == err_pc));
      end
    end
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////

  task automatic boot_sequence();
    alert_seen  = 1'b0;
    boot_addr_i = 32'h0000_40C4;
    req_i       = 1'b1;
    redirect(if_addr_pkg::PC_BOOT, if_addr_pkg::EXC_PC_EXC);
    expect_stream({boot_addr_i[31:8], if_addr_pkg::BootOffset}, 8, NoErr, 1'b0);
    if (alert_seen) begin
      report_problem("pc mismatch alert raised during sequential fetch");
    end
    finish_test("boot_seq");
  endtask

  task automatic target_redirects();
    branch_target_i = 32'h0000_2103;
    redirect(if_addr_pkg::PC_JUMP, if_addr_pkg::EXC_PC_EXC);
    expect_stream(branch_target_i & ~32'd3, 4, NoErr, 1'b0);
    csr_mepc_i = 32'h0000_3006;
    redirect(if_addr_pkg::PC_ERET, if_addr_pkg::EXC_PC_EXC);
    expect_stream(csr_mepc_i & ~32'd3, 4, NoErr, 1'b0);
    csr_depc_i = 32'h0000_5009;
    redirect(if_addr_pkg::PC_DRET, if_addr_pkg::EXC_PC_EXC);
    expect_stream(csr_depc_i & ~32'd3, 4, NoErr, 1'b0);
    finish_test("jump_returns");
  endtask

  task automatic exception_vectors();
    csr_mtvec_i = 32'h0000_8055;
    irq_id_i    = 5'd5;
    redirect(if_addr_pkg::PC_EXC, if_addr_pkg::EXC_PC_EXC);
    expect_stream({csr_mtvec_i[31:8], 8'h00}, 4, NoErr, 1'b0);
    redirect(if_addr_pkg::PC_EXC, if_addr_pkg::EXC_PC_IRQ);
    expect_stream({csr_mtvec_i[31:8], 8'h00} + 32'(irq_id_i) * 4, 4, NoErr, 1'b0);
    redirect(if_addr_pkg::PC_EXC, if_addr_pkg::EXC_PC_DBD);
    expect_stream(if_addr_pkg::DmHaltAddr, 4, NoErr, 1'b0);
    redirect(if_addr_pkg::PC_EXC, if_addr_pkg::EXC_PC_DBG_EXC);
    expect_stream(if_addr_pkg::DmExceptionAddr, 4, NoErr, 1'b0);
    finish_test("exc_vectors");
  endtask

  task automatic back_pressure();
    alert_seen      = 1'b0;
    branch_target_i = 32'h0000_6000;
    redirect(if_addr_pkg::PC_JUMP, if_addr_pkg::EXC_PC_EXC);
    expect_stream(32'h0000_6000, 16, NoErr, 1'b1);
    if (alert_seen) begin
      report_problem("pc mismatch alert raised under back-pressure");
    end
    finish_test("backpressure");
  endtask

  task automatic fetch_errors();
    int unsigned waited;
    branch_target_i = 32'h0000_7000;
    redirect(if_addr_pkg::PC_JUMP, if_addr_pkg::EXC_PC_EXC);
    expect_stream(32'h0000_7000, 4, ErrAddr, 1'b0);
    // park with a full queue and consume one word under a pmp fault
    id_in_ready_i   = 1'b0;
    branch_target_i = 32'h0000_7800;
    redirect(if_addr_pkg::PC_JUMP, if_addr_pkg::EXC_PC_EXC);
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
    end while (if_busy_o && waited < 40);
    if (if_busy_o) begin
      report_problem("prefetcher never went idle with ID stalled");
    end
    next_cycle();
    pmp_err_if_i  = 1'b1;
    id_in_ready_i = 1'b1;
    next_cycle();
    pmp_err_if_i = 1'b0;
    expect_stream(32'h0000_7800, 3, 32'h0000_7800, 1'b0);
    finish_test("fetch_errors");
  endtask

  task automatic valid_clear();
    int unsigned waited;
    if (instr_valid_id_o !== 1'b1) begin
      report_problem("no valid instruction in ID before the clear");
    end
    id_in_ready_i       = 1'b0;
    instr_valid_clear_i = 1'b1;
    next_cycle();
    instr_valid_clear_i = 1'b0;
    repeat (4) begin
      if (instr_valid_id_o !== 1'b0) begin
        report_mismatch("instr_valid_id_o", 32'(instr_valid_id_o), 32'd0);
      end
      next_cycle();
    end
    // valid must come back only with the next consume
    id_in_ready_i = 1'b1;
    waited = 0;
    do begin
      next_cycle();
      waited++;
      if (instr_valid_id_o !== instr_new_id_o) begin
        report_mismatch("instr_valid_id_o", 32'(instr_valid_id_o), 32'(instr_new_id_o));
      end
    end while (!instr_new_id_o && waited < 20);
    if (!instr_new_id_o) begin
      report_problem("no instruction consumed after the stall ended");
    end
    finish_test("valid_clear");
  endtask

  initial begin : main
    rst_ni              = 1'b0;
    req_i               = 1'b0;
    boot_addr_i         = '0;
    pc_set_i            = 1'b0;
    pc_sel_i            = if_addr_pkg::PC_BOOT;
    exc_pc_sel_i        = if_addr_pkg::EXC_PC_EXC;
    irq_id_i            = '0;
    branch_target_i     = '0;
    csr_mtvec_i         = '0;
    csr_mepc_i          = '0;
    csr_depc_i          = '0;
    pmp_err_if_i        = 1'b0;
    id_in_ready_i       = 1'b1;
    instr_valid_clear_i = 1'b0;
    alert_seen          = 1'b0;
    rng_rdy             = 32'd10;
    errors              = 0;
    errors_at_start     = 0;
    tests_run           = 0;
    tests_failed        = 0;
    repeat (2) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    next_cycle();
    if (instr_req_o || instr_valid_id_o || instr_new_id_o || pc_mismatch_alert_o ||
        csr_mtvec_init_o) begin
      report_problem("outputs not idle after reset");
    end
    boot_sequence();
    target_redirects();
    exception_vectors();
    back_pressure();
    fetch_errors();
    valid_clear();
    $display("tests run %0d, tests failed %0d, failed checks %0d",
             tests_run, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* ifs_fetch_stage.f */
rtl/if_addr_pkg.sv
rtl/if_bus_pkg.sv
rtl/pc_target_sel.sv
rtl/prefetch_buffer.sv
rtl/if_id_reg.sv
rtl/pc_incr_check.sv
rtl/ifs_fetch_stage.sv
sim/fetch_stage_assert.sv
sim/tb_fetch_stage.sv

/* run_sim.sh */
#!/bin/sh
# build and run the fetch stage testbench with Verilator
# the run passes only if sim.log holds the pass line

rm -rf obj_dir sim.log build.log \
  && verilator --binary --timing --assert -Wno-fatal \
       --top-module tb_fetch_stage -f ifs_fetch_stage.f -o tb_fetch_stage > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_fetch_stage > sim.log 2>&1

grep -qx "TEST OK" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
